// ==== bb_bus_pkg.sv ====
package bb_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // APB bus widths

    typedef logic [31:0] apb_addr_t;  // Byte address
    typedef logic [31:0] apb_data_t;  // Read and write data

    ////////////////////////////////////////////////////////////////////////////
    // Control page placement

    localparam int PAGE_LSB = 12;  // Page field starts here, 4 KB slots

    // Upper address bits that select the control page
    localparam logic [31-PAGE_LSB:0] PAGE_BASE = 20'h43C04;

    ////////////////////////////////////////////////////////////////////////////
    // Register offsets inside the page

    localparam logic [PAGE_LSB-1:0] REG_CTRL    = 12'h000;  // Source select
    localparam logic [PAGE_LSB-1:0] REG_TX_DATA = 12'h004;  // Raw word to send
    localparam logic [PAGE_LSB-1:0] REG_TX_PUSH = 12'h008;  // Byte enables, push strobe
    localparam logic [PAGE_LSB-1:0] REG_RX_DATA = 12'h00C;  // Received word, pop strobe
    localparam logic [PAGE_LSB-1:0] REG_STATUS  = 12'h010;  // Bridge flags
    localparam logic [PAGE_LSB-1:0] REG_BURST   = 12'h014;  // Capture burst length
    localparam logic [PAGE_LSB-1:0] REG_LED0    = 12'h018;  // LED0 brightness
    localparam logic [PAGE_LSB-1:0] REG_LED1    = 12'h01C;  // LED1 brightness

endpackage

// ==== bb_io_pkg.sv ====
package bb_io_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // USB bridge FIFO side

    typedef logic [31:0] usb_word_t;  // One bridge word
    typedef logic [3:0]  usb_be_t;    // One enable per byte lane

    ////////////////////////////////////////////////////////////////////////////
    // Sampled data and counters

    typedef logic [7:0]  adc_sample_t;  // Channel A, offset binary
    typedef logic [31:0] burst_cnt_t;   // Words left in a capture burst
    typedef logic [15:0] led_level_t;   // Brightness, low LED_DEPTH bits used

    ////////////////////////////////////////////////////////////////////////////
    // Source feeding the USB write port

    typedef enum logic [1:0] {
        SRC_RAW      = 2'd0,  // CPU pushes words by hand
        SRC_IDLE     = 2'd1,  // Nothing moves
        SRC_CAPTURE  = 2'd2,  // ADC A burst
        SRC_LOOPBACK = 2'd3   // Read port echoed to write port
    } usb_src_e;

endpackage

// ==== bb_ctrl_regs.sv ====
`timescale 1ns/100ps

module bb_ctrl_regs (
    input  logic                              clk,
    input  logic                              reset,

    // Write side, already decoded to this page
    input  logic                              wr_stb_i,
    input  logic [bb_bus_pkg::PAGE_LSB-1:0]   waddr_i,
    input  bb_bus_pkg::apb_data_t             pwdata_i,

    // Read side
    input  logic [bb_bus_pkg::PAGE_LSB-1:0]   raddr_i,
    output bb_bus_pkg::apb_data_t             prdata_o,

    // Bridge status and received words
    input  bb_io_pkg::usb_word_t              usb_rd_data_i,
    input  logic                              usb_rd_valid_i,
    input  logic                              usb_wr_full_i,
    input  logic                              usb_rd_empty_i,
    input  bb_io_pkg::burst_cnt_t             burst_remaining_i,

    // Fields toward the source mux
    output bb_io_pkg::usb_src_e               src_sel_o,
    output bb_io_pkg::usb_word_t              raw_data_o,
    output bb_io_pkg::usb_be_t                raw_be_o,
    output logic                              raw_wr_pulse_o,
    output logic                              raw_rd_pulse_o,
    output logic                              burst_load_o,
    output bb_io_pkg::burst_cnt_t             burst_count_o,

    // LED brightness
    output bb_io_pkg::led_level_t             led0_level_o,
    output bb_io_pkg::led_level_t             led1_level_o
);

    import bb_bus_pkg::*;
    import bb_io_pkg::*;

    usb_src_e   src_sel_q;     // Write port source
    usb_word_t  raw_data_q;    // Word for the raw push
    usb_be_t    raw_be_q;      // Lanes for the raw push
    logic       raw_wr_q;      // Push strobe
    logic       raw_rd_q;      // Pop strobe
    logic       burst_load_q;  // Counter load strobe
    burst_cnt_t burst_cnt_q;   // Value to load
    led_level_t led0_q;
    led_level_t led1_q;
    usb_word_t  rx_word_q;     // Last word seen on the read port

    ////////////////////////////////////////////////////////////////////////////
    // Writable fields and strobes

    always_ff @(posedge clk) begin
        if (reset) begin
            src_sel_q    <= SRC_IDLE;  // Quiet bridge out of reset
            raw_data_q   <= '0;
            raw_be_q     <= '0;
            raw_wr_q     <= 1'b0;
            raw_rd_q     <= 1'b0;
            burst_load_q <= 1'b0;
            burst_cnt_q  <= '0;
            led0_q       <= '0;
            led1_q       <= '0;
        end else begin
            // Strobes last one cycle only
            raw_wr_q     <= 1'b0;
            raw_rd_q     <= 1'b0;
            burst_load_q <= 1'b0;

            if (wr_stb_i) begin
                case (waddr_i)
                    REG_CTRL:    src_sel_q  <= usb_src_e'(pwdata_i[1:0]);
                    REG_TX_DATA: raw_data_q <= pwdata_i;
                    REG_TX_PUSH: begin
                        raw_be_q <= pwdata_i[3:0];
                        raw_wr_q <= 1'b1;  // Word goes out next cycle
                    end
                    REG_RX_DATA: raw_rd_q <= 1'b1;  // Write value ignored
                    REG_BURST: begin
                        burst_cnt_q  <= pwdata_i;
                        burst_load_q <= 1'b1;  // Counter takes it a cycle later
                    end
                    REG_LED0:    led0_q <= pwdata_i[15:0];
                    REG_LED1:    led1_q <= pwdata_i[15:0];
                    default: ;  // Status and holes are read only
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Received word latch

    // Runs whatever the source, so loopback traffic shows up here too
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_word_q <= '0;
        end else if (usb_rd_valid_i) begin
            rx_word_q <= usb_rd_data_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read-back

    always_comb begin
        case (raddr_i)
            REG_CTRL:    prdata_o = {30'b0, src_sel_q};
            REG_TX_DATA: prdata_o = raw_data_q;
            REG_TX_PUSH: prdata_o = {28'b0, raw_be_q};
            REG_RX_DATA: prdata_o = rx_word_q;
            REG_STATUS:  prdata_o = {30'b0, usb_rd_empty_i, usb_wr_full_i};
            REG_BURST:   prdata_o = burst_remaining_i;  // Live count, not the load value
            REG_LED0:    prdata_o = {16'b0, led0_q};
            REG_LED1:    prdata_o = {16'b0, led1_q};
            default:     prdata_o = '0;  // Unmapped offsets
        endcase
    end

    // Outputs
    assign src_sel_o      = src_sel_q;
    assign raw_data_o     = raw_data_q;
    assign raw_be_o       = raw_be_q;
    assign raw_wr_pulse_o = raw_wr_q;
    assign raw_rd_pulse_o = raw_rd_q;
    assign burst_load_o   = burst_load_q;
    assign burst_count_o  = burst_cnt_q;
    assign led0_level_o   = led0_q;
    assign led1_level_o   = led1_q;

endmodule

// ==== bb_usb_source_mux.sv ====
`timescale 1ns/100ps

module bb_usb_source_mux (
    input  logic                   clk,
    input  logic                   reset,

    input  bb_io_pkg::usb_src_e    src_sel_i,

    // CPU raw path
    input  bb_io_pkg::usb_word_t   raw_data_i,
    input  bb_io_pkg::usb_be_t     raw_be_i,
    input  logic                   raw_wr_pulse_i,
    input  logic                   raw_rd_pulse_i,

    // Capture burst
    input  logic                   burst_load_i,
    input  bb_io_pkg::burst_cnt_t  burst_count_i,
    input  bb_io_pkg::adc_sample_t adc_sample_i,

    // Bridge read port and flags
    input  bb_io_pkg::usb_word_t   usb_rd_data_i,
    input  bb_io_pkg::usb_be_t     usb_rd_be_i,
    input  logic                   usb_rd_valid_i,
    input  logic                   usb_wr_full_i,

    // Bridge write port
    output bb_io_pkg::usb_word_t   usb_wr_data_o,
    output bb_io_pkg::usb_be_t     usb_wr_be_o,
    output logic                   usb_wr_en_o,
    output logic                   usb_rd_en_o,

    output bb_io_pkg::burst_cnt_t  burst_remaining_o
);

    import bb_io_pkg::*;

    burst_cnt_t remaining_q;  // Words still to send
    logic       burst_active;

    ////////////////////////////////////////////////////////////////////////////
    // Burst down-counter

    // Counts down in every mode, so a burst can drain while not selected
    always_ff @(posedge clk) begin
        if (reset) begin
            remaining_q <= '0;
        end else if (burst_load_i) begin
            remaining_q <= burst_count_i;
        end else if (burst_active) begin
            remaining_q <= remaining_q - 1'b1;
        end
    end

    assign burst_active      = (remaining_q != '0);
    assign burst_remaining_o = remaining_q;

    ////////////////////////////////////////////////////////////////////////////
    // Four-way source select

    always_comb begin
        case (src_sel_i)
            SRC_RAW: begin
                usb_wr_data_o = raw_data_i;
                usb_wr_be_o   = raw_be_i;
                usb_wr_en_o   = raw_wr_pulse_i;
                usb_rd_en_o   = raw_rd_pulse_i;
            end
            SRC_CAPTURE: begin
                usb_wr_data_o = usb_word_t'(adc_sample_i);  // Zero-extended
                usb_wr_be_o   = 4'hF;
                usb_wr_en_o   = burst_active;  // No back-pressure here
                usb_rd_en_o   = 1'b1;          // Keep read side drained
            end
            SRC_LOOPBACK: begin
                usb_wr_data_o = usb_rd_data_i;
                usb_wr_be_o   = usb_rd_be_i;
                usb_wr_en_o   = usb_rd_valid_i;
                usb_rd_en_o   = !usb_wr_full_i;  // Only pull what can be pushed
            end
            default: begin  // SRC_IDLE
                usb_wr_data_o = '0;
                usb_wr_be_o   = 4'hF;
                usb_wr_en_o   = 1'b0;
                usb_rd_en_o   = 1'b0;
            end
        endcase
    end

endmodule

// ==== bb_led_ddac.sv ====
`timescale 1ns/100ps

// First-order delta-sigma dimmer
module bb_led_ddac #(
    parameter int LED_DEPTH = 16  // Accumulator width, 4 to 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  bb_io_pkg::led_level_t   level_i,  // Duty is level over 2^LED_DEPTH
    output logic                    pwm_o
);

    logic [LED_DEPTH-1:0] acc_q;
    logic [LED_DEPTH:0]   sum;  // Extra bit holds the carry

    // Only the low bits of the level take part
    assign sum = {1'b0, acc_q} + {1'b0, level_i[LED_DEPTH-1:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_q <= '0;
            pwm_o <= 1'b0;  // LED dark until first carry
        end else begin
            acc_q <= sum[LED_DEPTH-1:0];
            pwm_o <= sum[LED_DEPTH];  // Carry spreads the on cycles
        end
    end

endmodule

// ==== bb_baseband_top.sv ====
`timescale 1ns/100ps

module bb_baseband_top #(
    parameter int LED_DEPTH = 16  // Dimmer resolution
) (
    input  logic                   clk,
    input  logic                   reset,

    // APB slave
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  bb_bus_pkg::apb_addr_t  paddr_i,
    input  logic                   pwrite_i,
    input  bb_bus_pkg::apb_data_t  pwdata_i,
    output bb_bus_pkg::apb_data_t  prdata_o,

    // ADC channel A
    input  bb_io_pkg::adc_sample_t adc_sample_i,

    // USB bridge FIFO side
    output bb_io_pkg::usb_word_t   usb_wr_data_o,
    output bb_io_pkg::usb_be_t     usb_wr_be_o,
    output logic                   usb_wr_en_o,
    input  logic                   usb_wr_full_i,
    input  bb_io_pkg::usb_word_t   usb_rd_data_i,
    input  bb_io_pkg::usb_be_t     usb_rd_be_i,
    input  logic                   usb_rd_valid_i,
    input  logic                   usb_rd_empty_i,
    output logic                   usb_rd_en_o,

    // Board LEDs
    output logic                   led0_o,
    output logic                   led1_o
);

    import bb_bus_pkg::*;
    import bb_io_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Page decode

    logic                page_hit;
    logic                wr_stb;
    logic [PAGE_LSB-1:0] reg_off;
    apb_data_t           regs_prdata;

    assign page_hit = (paddr_i[31:PAGE_LSB] == PAGE_BASE);
    assign wr_stb   = psel_i && penable_i && pwrite_i && page_hit;  // Access phase
    assign reg_off  = paddr_i[PAGE_LSB-1:0];
    assign prdata_o = page_hit ? regs_prdata : '0;  // Other pages read zero

    // Register to datapath wiring
    usb_src_e   src_sel;
    usb_word_t  raw_data;
    usb_be_t    raw_be;
    logic       raw_wr_pulse;
    logic       raw_rd_pulse;
    logic       burst_load;
    burst_cnt_t burst_count;
    burst_cnt_t burst_remaining;
    led_level_t led0_level;
    led_level_t led1_level;

    bb_ctrl_regs regs_i (
        .clk               (clk),
        .reset             (reset),
        .wr_stb_i          (wr_stb),
        .waddr_i           (reg_off),
        .pwdata_i          (pwdata_i),
        .raddr_i           (reg_off),
        .prdata_o          (regs_prdata),
        .usb_rd_data_i     (usb_rd_data_i),
        .usb_rd_valid_i    (usb_rd_valid_i),
        .usb_wr_full_i     (usb_wr_full_i),
        .usb_rd_empty_i    (usb_rd_empty_i),
        .burst_remaining_i (burst_remaining),
        .src_sel_o         (src_sel),
        .raw_data_o        (raw_data),
        .raw_be_o          (raw_be),
        .raw_wr_pulse_o    (raw_wr_pulse),
        .raw_rd_pulse_o    (raw_rd_pulse),
        .burst_load_o      (burst_load),
        .burst_count_o     (burst_count),
        .led0_level_o      (led0_level),
        .led1_level_o      (led1_level)
    );

    ////////////////////////////////////////////////////////////////////////////
    // USB write source

    bb_usb_source_mux usb_mux_i (
        .clk               (clk),
        .reset             (reset),
        .src_sel_i         (src_sel),
        .raw_data_i        (raw_data),
        .raw_be_i          (raw_be),
        .raw_wr_pulse_i    (raw_wr_pulse),
        .raw_rd_pulse_i    (raw_rd_pulse),
        .burst_load_i      (burst_load),
        .burst_count_i     (burst_count),
        .adc_sample_i      (adc_sample_i),
        .usb_rd_data_i     (usb_rd_data_i),
        .usb_rd_be_i       (usb_rd_be_i),
        .usb_rd_valid_i    (usb_rd_valid_i),
        .usb_wr_full_i     (usb_wr_full_i),
        .usb_wr_data_o     (usb_wr_data_o),
        .usb_wr_be_o       (usb_wr_be_o),
        .usb_wr_en_o       (usb_wr_en_o),
        .usb_rd_en_o       (usb_rd_en_o),
        .burst_remaining_o (burst_remaining)
    );

    // LED dimmers
    bb_led_ddac #(.LED_DEPTH(LED_DEPTH)) led0_ddac_i (
        .clk     (clk),
        .reset   (reset),
        .level_i (led0_level),
        .pwm_o   (led0_o)
    );

    bb_led_ddac #(.LED_DEPTH(LED_DEPTH)) led1_ddac_i (
        .clk     (clk),
        .reset   (reset),
        .level_i (led1_level),
        .pwm_o   (led1_o)
    );

endmodule

// ==== bb_baseband_properties.sv ====
`timescale 1ns/100ps

module bb_baseband_properties (
    input logic                clk,
    input logic                reset,
    input bb_io_pkg::usb_src_e src_sel_i,
    input logic                wr_en_i,
    input logic                rd_en_i,
    input logic                wr_full_i
);

    import bb_io_pkg::*;

    // Idle source keeps both bridge strobes quiet
    idle_no_write: assert property (@(posedge clk) disable iff (reset)
        (src_sel_i == SRC_IDLE) |-> !wr_en_i)
        else $error("Write enable high while the source is idle");

    idle_no_read: assert property (@(posedge clk) disable iff (reset)
        (src_sel_i == SRC_IDLE) |-> !rd_en_i)
        else $error("Read enable high while the source is idle");

    // Loopback pulls a word only when the write side has room
    loop_room: assert property (@(posedge clk) disable iff (reset)
        (src_sel_i == SRC_LOOPBACK && rd_en_i) |-> !wr_full_i)
        else $error("Loopback read enable while the write FIFO is full");

endmodule

bind bb_usb_source_mux bb_baseband_properties usb_mux_props_i (
    .clk       (clk),
    .reset     (reset),
    .src_sel_i (src_sel_i),
    .wr_en_i   (usb_wr_en_o),
    .rd_en_i   (usb_rd_en_o),
    .wr_full_i (usb_wr_full_i)
);

// ==== tb_bb_baseband.sv ====
`timescale 1ns/100ps

module tb_bb_baseband;

    import bb_bus_pkg::*;
    import bb_io_pkg::*;

    localparam int LED_DEPTH  = 8;
    localparam int WINDOW     = 1 << LED_DEPTH;  // One full dimmer period
    localparam int BURST_LONG = 40;
    localparam int LOOP_LEN   = 100;
    // Two LED windows, loopback, bursts and about 80 three-cycle APB accesses
    localparam int CYCLE_LIMIT = 3 * (2 * WINDOW + LOOP_LEN + BURST_LONG + 3 * 80);

    logic        clk            = 1'b0;
    logic        reset          = 1'b1;
    logic        psel_i         = 1'b0;
    logic        penable_i      = 1'b0;
    apb_addr_t   paddr_i        = '0;
    logic        pwrite_i       = 1'b0;
    apb_data_t   pwdata_i       = '0;
    apb_data_t   prdata_o;
    adc_sample_t adc_sample_i   = '0;
    usb_word_t   usb_wr_data_o;
    usb_be_t     usb_wr_be_o;
    logic        usb_wr_en_o;
    logic        usb_wr_full_i  = 1'b0;
    usb_word_t   usb_rd_data_i  = '0;
    usb_be_t     usb_rd_be_i    = '0;
    logic        usb_rd_valid_i = 1'b0;
    logic        usb_rd_empty_i = 1'b0;
    logic        usb_rd_en_o;
    logic        led0_o;
    logic        led1_o;

    integer      seed = 90;
    logic [31:0] rnd_word;
    logic [31:0] rnd_bits;
    logic        rand_on      = 1'b0;      // Read port randomized
    usb_src_e    exp_src      = SRC_IDLE;  // Source field as last written
    usb_word_t   exp_raw_word = '0;
    usb_be_t     exp_raw_be   = '0;
    logic        wr_en_prev   = 1'b0;
    int          check_count  = 0;
    int          error_count  = 0;
    int          cycle_count  = 0;
    int          wr_en_count  = 0;
    int          wr_runs      = 0;         // Separate bursts of write enables
    int          led0_high    = 0;
    int          led1_high    = 0;
    apb_data_t   rd_word;

    bb_baseband_top #(.LED_DEPTH(LED_DEPTH)) bb_baseband_top_i (.*);

    always #4 clk = ~clk;  // 8 ns period

    ////////////////////////////////////////////////////////////////////////////
    // Reference rules

    function automatic apb_addr_t reg_addr(logic [PAGE_LSB-1:0] off);
        return {PAGE_BASE, off};
    endfunction

    function automatic apb_data_t expect_readback(apb_addr_t addr, apb_data_t value);
        if (addr[31:PAGE_LSB] != PAGE_BASE)
            return '0;  // Foreign page
        case (addr[PAGE_LSB-1:0])
            REG_CTRL, REG_STATUS:                return value & 32'h3;
            REG_TX_PUSH:                         return value & 32'hF;
            REG_LED0, REG_LED1:                  return value & 32'hFFFF;
            REG_TX_DATA, REG_RX_DATA, REG_BURST: return value;
            default:                             return '0;  // Hole in the map
        endcase
    endfunction

    // Byte enables above the word
    function automatic logic [35:0] expect_write(usb_src_e src, adc_sample_t sample,
                                                 usb_word_t rd_data, usb_be_t rd_be);
        case (src)
            SRC_RAW:      return {exp_raw_be, exp_raw_word};
            SRC_CAPTURE:  return {4'hF, 24'h0, sample};
            SRC_LOOPBACK: return {rd_be, rd_data};
            default:      return '0;
        endcase
    endfunction

    // High cycles per full window at a constant level
    function automatic int expect_led_high(led_level_t level);
        return int'(level) % WINDOW;
    endfunction

    task automatic compare_value(string name, logic [35:0] got, logic [35:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // APB accesses

    task automatic apb_write(apb_addr_t addr, apb_data_t data);
        @(posedge clk);
        psel_i    <= 1'b1;
        paddr_i   <= addr;
        pwrite_i  <= 1'b1;
        pwdata_i  <= data;
        @(posedge clk);
        penable_i <= 1'b1;
        @(posedge clk);  // Registers take the write here
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
        if (addr[31:PAGE_LSB] == PAGE_BASE) begin
            case (addr[PAGE_LSB-1:0])
                REG_CTRL:    exp_src      = usb_src_e'(data[1:0]);
                REG_TX_DATA: exp_raw_word = data;
                REG_TX_PUSH: exp_raw_be   = data[3:0];
                default: ;
            endcase
        end
    endtask

    task automatic apb_read(apb_addr_t addr);
        @(posedge clk);
        psel_i    <= 1'b1;
        paddr_i   <= addr;
        @(posedge clk);
        penable_i <= 1'b1;
        @(negedge clk);
        rd_word = prdata_o;  // No wait states
        @(posedge clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic read_check(apb_addr_t addr, apb_data_t value);
        apb_read(addr);
        compare_value("prdata_o", rd_word, expect_readback(addr, value));
    endtask

    task automatic run_burst(int len);
        wr_en_count = 0;
        wr_runs     = 0;
        apb_write(reg_addr(REG_BURST), len);
        do begin
            apb_read(reg_addr(REG_BURST));
        end while (rd_word != '0);
        compare_value("usb_wr_en_o cycles", wr_en_count, len);
        compare_value("usb_wr_en_o runs", wr_runs, 1);  // One unbroken run
        read_check(reg_addr(REG_BURST), 0);
    endtask

    task automatic led_window(apb_data_t level0, apb_data_t level1);
        apb_write(reg_addr(REG_LED0), level0);
        apb_write(reg_addr(REG_LED1), level1);
        repeat (2) @(posedge clk);  // New level reaches the carry flop
        led0_high = 0;
        led1_high = 0;
        repeat (WINDOW) @(posedge clk);
        compare_value("led0_o high cycles", led0_high, expect_led_high(level0));
        compare_value("led1_o high cycles", led1_high, expect_led_high(level1));
        read_check(reg_addr(REG_LED0), level0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus, compare and timeout processes

    always @(posedge clk) begin
        rnd_word = $random(seed);
        rnd_bits = $random(seed);
        adc_sample_i <= rnd_bits[7:0];  // Always moving
        if (rand_on) begin
            usb_rd_data_i  <= rnd_word;
            usb_rd_be_i    <= rnd_bits[11:8];
            usb_rd_valid_i <= rnd_bits[12];
            usb_wr_full_i  <= rnd_bits[13];
            usb_rd_empty_i <= rnd_bits[14];
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (usb_wr_en_o) begin
                compare_value("{usb_wr_be_o, usb_wr_data_o}", {usb_wr_be_o, usb_wr_data_o},
                              expect_write(exp_src, adc_sample_i, usb_rd_data_i, usb_rd_be_i));
                wr_en_count++;
                if (!wr_en_prev)
                    wr_runs++;
            end
            wr_en_prev = usb_wr_en_o;
            if (exp_src == SRC_IDLE) begin
                compare_value("usb_wr_en_o", usb_wr_en_o, 0);
                compare_value("usb_rd_en_o", usb_rd_en_o, 0);
            end
            if (exp_src == SRC_CAPTURE)
                compare_value("usb_rd_en_o", usb_rd_en_o, 1);  // Read side held open
            if (exp_src == SRC_LOOPBACK) begin
                compare_value("usb_wr_en_o", usb_wr_en_o, usb_rd_valid_i);
                compare_value("usb_rd_en_o", usb_rd_en_o, !usb_wr_full_i);
            end
            led0_high += led0_o;
            led1_high += led1_o;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Timeout, run still busy after %0d cycles", CYCLE_LIMIT);
            $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // Read-back and page decode
        read_check(reg_addr(REG_CTRL), SRC_IDLE);
        apb_write(reg_addr(REG_TX_DATA), 32'hC0DE_5A11);
        apb_write(reg_addr(REG_LED0), 32'hBEEF_1234);
        apb_write(reg_addr(REG_CTRL), 32'h0000_00F1);  // Still idle
        read_check(reg_addr(REG_CTRL), 32'h0000_00F1);
        read_check(reg_addr(REG_TX_DATA), 32'hC0DE_5A11);
        read_check(reg_addr(REG_LED0), 32'hBEEF_1234);
        read_check({PAGE_BASE + 20'd1, REG_TX_DATA}, 32'hC0DE_5A11);
        read_check(reg_addr(12'h020), 32'hC0DE_5A11);

        // Raw push, pop and received word
        apb_write(reg_addr(REG_CTRL), SRC_RAW);
        wr_en_count = 0;
        apb_write(reg_addr(REG_TX_PUSH), 32'h0000_0006);
        @(negedge clk);
        compare_value("usb_wr_en_o", usb_wr_en_o, 1);
        @(negedge clk);
        compare_value("usb_wr_en_o", usb_wr_en_o, 0);
        apb_write(reg_addr(REG_RX_DATA), 32'h0);
        @(negedge clk);
        compare_value("usb_rd_en_o", usb_rd_en_o, 1);
        @(negedge clk);
        compare_value("usb_rd_en_o", usb_rd_en_o, 0);
        @(posedge clk);
        usb_rd_data_i  <= 32'h1357_9BDF;
        usb_rd_valid_i <= 1'b1;
        @(posedge clk);
        usb_rd_valid_i <= 1'b0;
        read_check(reg_addr(REG_RX_DATA), 32'h1357_9BDF);
        compare_value("usb_wr_en_o cycles", wr_en_count, 1);

        // Capture bursts
        apb_write(reg_addr(REG_CTRL), SRC_CAPTURE);
        run_burst(1);
        run_burst(BURST_LONG);

        // Loopback against random read port traffic
        rand_on <= 1'b1;
        apb_write(reg_addr(REG_CTRL), SRC_LOOPBACK);
        repeat (LOOP_LEN) @(posedge clk);

        // Idle, LED windows for levels 37, 255 and 0, then status flags
        apb_write(reg_addr(REG_CTRL), SRC_IDLE);
        led_window(32'h0000_0025, 32'h0000_00FF);
        led_window(32'h0000_0100, 32'h0000_0025);  // Bit 8 is above the depth
        rand_on <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            usb_wr_full_i  <= i[0];
            usb_rd_empty_i <= i[1];
            read_check(reg_addr(REG_STATUS), i);
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
bb_bus_pkg.sv
bb_io_pkg.sv
bb_ctrl_regs.sv
bb_usb_source_mux.sv
bb_led_ddac.sv
bb_baseband_top.sv
bb_baseband_properties.sv
tb_bb_baseband.sv
